/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_ara
RTL_TOP   = ara
FILELIST  = filelist.f
BUILD     = obj_dir
LOG       = sim.log
PASS      = Done: no errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* ara.sv */
//////////////////////////////////////////////////////////////////////
// Vector accelerator top, dispatcher, sequencer and a row of lanes
// NrLanes must be a power of two, at least 2
// VLEN must be a power of two with VLEN/(NrLanes*32) at least 2
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Core interface
  input  ara_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output ara_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output logic               idle_o
);
  import ara_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////////////////////////

  pe_req_t   ara_req;
  logic      ara_req_valid;
  logic      ara_req_ready;
  acc_resp_t ara_resp;
  logic      ara_resp_valid;
  logic      busy;

  ara_dispatcher i_dispatcher (
    .clk_i           (clk_i           ),
    .reset_i         (reset_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .ara_req_o       (ara_req         ),
    .ara_req_valid_o (ara_req_valid   ),
    .ara_req_ready_i (ara_req_ready   ),
    .ara_resp_i      (ara_resp        ),
    .ara_resp_valid_i(ara_resp_valid  ),
    .busy_o          (busy            )
  );

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  pe_req_t                  pe_req;
  logic                     pe_req_valid;
  logic     [NrLanes-1:0]   pe_req_ready;
  pe_resp_t [NrLanes-1:0]   pe_resp;
  logic     [NrLanes-1:0]   lanes_idle;

  ara_sequencer #(
    .NrLanes(NrLanes),
    .VLEN   (VLEN   )
  ) i_sequencer (
    .clk_i           (clk_i         ),
    .reset_i         (reset_i       ),
    .ara_req_i       (ara_req       ),
    .ara_req_valid_i (ara_req_valid ),
    .ara_req_ready_o (ara_req_ready ),
    .ara_resp_o      (ara_resp      ),
    .ara_resp_valid_o(ara_resp_valid),
    .pe_req_o        (pe_req        ),
    .pe_req_valid_o  (pe_req_valid  ),
    .pe_req_ready_i  (pe_req_ready  ),
    .pe_resp_i       (pe_resp       ),
    .lanes_idle_i    (lanes_idle    ),
    .busy_i          (busy          ),
    .idle_o          (idle_o        )
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    lane #(
      .NrLanes(NrLanes),
      .VLEN   (VLEN   ),
      .LaneId (l      )
    ) i_lane (
      .clk_i         (clk_i          ),
      .reset_i       (reset_i        ),
      .pe_req_i      (pe_req         ),
      .pe_req_valid_i(pe_req_valid   ),
      .pe_req_ready_o(pe_req_ready[l]),
      .pe_resp_o     (pe_resp[l]     ),
      .idle_o        (lanes_idle[l]  )
    );
  end

endmodule

/* ara_checker.sv */
//////////////////////////////////////////////////////////////////////
// Watches the core ports of the accelerator and compares responses
// Register model updates at each request transfer
// Extract indices wrap at VLEN/32
// Reserved codes leave the model unchanged
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_checker #(
  parameter int unsigned VLEN = 512
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  ara_pkg::acc_req_t  req_i,
  input  logic               req_valid_i,
  input  logic               req_ready_i,
  input  ara_pkg::acc_resp_t resp_i,
  input  logic               resp_valid_i,
  input  logic               resp_ready_i,
  input  logic               idle_i,
  input  logic               done_i,
  output int unsigned        errors_o
);
  import ara_pkg::*;

  localparam int unsigned NrElems = VLEN / ElemWidth;

  elem_t       model_q [NrVRegs][NrElems];
  acc_resp_t   exp_q [$];
  string       name_q [$];
  acc_resp_t   held_resp;
  logic        held_valid;
  logic        first_cycle;
  logic        reported = 1'b0;
  int unsigned nr_reqs = 0;
  int unsigned nr_resps = 0;
  int unsigned value_errs = 0;
  int unsigned proto_errs = 0;

  assign errors_o = value_errs + proto_errs;

  function automatic string op_name(logic [2:0] op);
    case (op)
      3'(OP_VADD):     return "vadd";
      3'(OP_VXOR):     return "vxor";
      3'(OP_VAND):     return "vand";
      3'(OP_VSPLAT):   return "vsplat";
      3'(OP_VEXTRACT): return "vextract";
      default:         return "reserved";
    endcase
  endfunction

  // Element rule of the integer ops
  function automatic elem_t elem_result(logic [2:0] op, elem_t a, elem_t b, elem_t s);
    case (op)
      3'(OP_VADD): return a + b;
      3'(OP_VXOR): return a ^ b;
      3'(OP_VAND): return a & b;
      default:     return s;
    endcase
  endfunction

  always @(posedge clk_i) begin
    acc_resp_t   exp;
    int unsigned idx;
    if (reset_i) begin
      foreach (model_q[r, e]) begin
        model_q[r][e] = '0;
      end
      exp_q.delete();
      name_q.delete();
      held_valid  = 1'b0;
      first_cycle = 1'b1;
    end else begin
      if (first_cycle &&
          (resp_valid_i !== 1'b0 || idle_i !== 1'b1 || req_ready_i !== 1'b1)) begin
        proto_errs++;
        $display("ERROR: after reset idle_o=%b acc_req_ready_o=%b acc_resp_valid_o=%b",
                 idle_i, req_ready_i, resp_valid_i);
      end
      first_cycle = 1'b0;
      if (idle_i !== 1'b0 && (exp_q.size() != 0 || resp_valid_i)) begin
        proto_errs++;
        $display("ERROR: idle_o is high while a response is still pending");
      end

      //////////////////////////////////////////////////////////////////////
      // Response side
      //////////////////////////////////////////////////////////////////////

      if (held_valid && resp_valid_i !== 1'b1) begin
        proto_errs++;
        $display("ERROR: acc_resp_valid_o dropped before the core took the response");
      end else if (held_valid && resp_i !== held_resp) begin
        proto_errs++;
        $display("ERROR: the response changed while the core was stalling it");
      end
      held_valid = resp_valid_i && !resp_ready_i;
      held_resp  = resp_i;
      if (resp_valid_i && resp_ready_i) begin
        nr_resps++;
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("ERROR: a response arrived with no request outstanding");
        end else begin
          exp = exp_q.pop_front();
          if (resp_i !== exp) begin
            value_errs++;
            $display("FAIL %s: expected result %h error %b, actual result %h error %b",
                     name_q[0], exp.result, exp.error, resp_i.result, resp_i.error);
          end
          void'(name_q.pop_front());
        end
      end

      //////////////////////////////////////////////////////////////////////
      // Request side and model update
      //////////////////////////////////////////////////////////////////////

      if (req_valid_i && req_ready_i) begin
        nr_reqs++;
        exp = '{result: '0, error: 1'b0};
        case (req_i.op)
          3'(OP_VADD), 3'(OP_VXOR), 3'(OP_VAND), 3'(OP_VSPLAT): begin
            for (int e = 0; e < NrElems; e++) begin
              model_q[req_i.vd][e] = elem_result(req_i.op, model_q[req_i.vs1][e],
                                                 model_q[req_i.vs2][e], req_i.scalar);
            end
          end
          3'(OP_VEXTRACT): begin
            idx        = req_i.scalar % NrElems;
            exp.result = model_q[req_i.vs2][idx];
          end
          default: exp.error = 1'b1;
        endcase
        exp_q.push_back(exp);
        name_q.push_back($sformatf("%s #%0d", op_name(req_i.op), nr_reqs));
      end

      if (done_i && !reported) begin
        reported = 1'b1;
        if (exp_q.size() != 0) begin
          proto_errs++;
          $display("ERROR: %0d responses never arrived", exp_q.size());
        end
        $display("Checked %0d requests, %0d responses: %0d value errors, %0d protocol errors",
                 nr_reqs, nr_resps, value_errs, proto_errs);
      end
    end
  end

endmodule

/* ara_dispatcher.sv */
//////////////////////////////////////////////////////////////////////
// Core-side front end, one request outstanding at a time
// Reserved opcodes are answered here and never reach the lanes
// The response is held until the core takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_dispatcher (
  input  logic                clk_i,
  input  logic                reset_i,
  // Core side
  input  ara_pkg::acc_req_t   acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output ara_pkg::acc_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  // Sequencer side
  output ara_pkg::pe_req_t    ara_req_o,
  output logic                ara_req_valid_o,
  input  logic                ara_req_ready_i,
  input  ara_pkg::acc_resp_t  ara_resp_i,
  input  logic                ara_resp_valid_i,
  output logic                busy_o
);
  import ara_pkg::*;

  logic      busy_q;
  logic      fwd_valid_q;
  logic      resp_valid_q;
  pe_req_t   fwd_q;
  acc_resp_t resp_q;

  logic accept;
  logic reserved;
  logic resp_done;

  assign acc_req_ready_o = !busy_q;
  assign accept          = acc_req_valid_i && acc_req_ready_o;
  // Codes above the extract are reserved
  assign reserved        = acc_req_i.op > 3'(OP_VEXTRACT);
  assign resp_done       = resp_valid_q && acc_resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q       <= 1'b0;
      fwd_valid_q  <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q       <= 1'b1;
        fwd_valid_q  <= !reserved;
        resp_valid_q <= reserved;
      end
      if (fwd_valid_q && ara_req_ready_i) begin
        fwd_valid_q <= 1'b0;
      end
      if (ara_resp_valid_i) begin
        resp_valid_q <= 1'b1;
      end
      // Request retires once the core takes the response
      if (resp_done) begin
        resp_valid_q <= 1'b0;
        busy_q       <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      fwd_q.op      <= ara_op_e'(acc_req_i.op);
      fwd_q.vd      <= acc_req_i.vd;
      fwd_q.vs1     <= acc_req_i.vs1;
      fwd_q.vs2     <= acc_req_i.vs2;
      fwd_q.scalar  <= acc_req_i.scalar;
      fwd_q.is_last <= acc_req_i.op == 3'(OP_VEXTRACT);
      resp_q        <= '{result: '0, error: 1'b1};
    end else if (ara_resp_valid_i) begin
      resp_q <= ara_resp_i;
    end
  end

  assign ara_req_o        = fwd_q;
  assign ara_req_valid_o  = fwd_valid_q;
  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;
  assign busy_o           = busy_q;

endmodule

/* ara_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the vector accelerator
// Elements are fixed at 32 bits and vl is always the full register
// Opcode codes 5 to 7 are reserved and rejected by the dispatcher
//////////////////////////////////////////////////////////////////////

package ara_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [ElemWidth-1:0]       elem_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD     = 3'd0,
    OP_VXOR     = 3'd1,
    OP_VAND     = 3'd2,
    OP_VSPLAT   = 3'd3,
    OP_VEXTRACT = 3'd4
  } ara_op_e;

  //////////////////////////////////////////////////////////////////////
  // Core channel
  //////////////////////////////////////////////////////////////////////

  // Raw opcode bits, reserved codes can arrive here
  typedef struct packed {
    logic [2:0] op;
    vreg_t      vd;
    vreg_t      vs1;
    vreg_t      vs2;
    elem_t      scalar;
  } acc_req_t;

  typedef struct packed {
    elem_t result;
    logic  error;
  } acc_resp_t;

  //////////////////////////////////////////////////////////////////////
  // Lane channel
  //////////////////////////////////////////////////////////////////////

  // Scalar is the splat value or the element index of an extract
  typedef struct packed {
    ara_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
    logic    is_last;
  } pe_req_t;

  typedef struct packed {
    logic  valid;
    elem_t value;
  } pe_resp_t;

endpackage

/* ara_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Broadcasts instructions to all lanes and gathers extract results
// NrLanes must be a power of two and at least 2
// VLEN must be a power of two, extract indices wrap at VLEN/32
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_sequencer #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // Dispatcher side
  input  ara_pkg::pe_req_t                  ara_req_i,
  input  logic                              ara_req_valid_i,
  output logic                              ara_req_ready_o,
  output ara_pkg::acc_resp_t                ara_resp_o,
  output logic                              ara_resp_valid_o,
  // Lane side
  output ara_pkg::pe_req_t                  pe_req_o,
  output logic                              pe_req_valid_o,
  input  logic [NrLanes-1:0]                pe_req_ready_i,
  input  ara_pkg::pe_resp_t [NrLanes-1:0]   pe_resp_i,
  input  logic [NrLanes-1:0]                lanes_idle_i,
  input  logic                              busy_i,
  output logic                              idle_o
);
  import ara_pkg::*;

  localparam int unsigned NrElems  = VLEN / ElemWidth;
  localparam int unsigned ElemIdxW = $clog2(NrElems);
  localparam int unsigned LaneIdxW = $clog2(NrLanes);

  logic                all_ready;
  logic                issue;
  logic                owner_strobe;
  logic                wait_q;
  logic [LaneIdxW-1:0] owner_q;
  logic                resp_valid_q;
  elem_t               resp_result_q;

  //////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////

  // All lanes take the instruction in the same cycle
  assign all_ready       = &pe_req_ready_i;
  assign pe_req_valid_o  = ara_req_valid_i && !wait_q;
  assign ara_req_ready_o = all_ready && !wait_q;
  assign issue           = pe_req_valid_o && all_ready;

  always_comb begin
    pe_req_o = ara_req_i;
    // Wrap the element index into the register
    if (ara_req_i.is_last) begin
      pe_req_o.scalar = elem_t'(ara_req_i.scalar[ElemIdxW-1:0]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Responses
  //////////////////////////////////////////////////////////////////////

  // Only the lane holding the element may answer
  assign owner_strobe = wait_q && pe_resp_i[owner_q].valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= (issue && !ara_req_i.is_last) || owner_strobe;
      if (issue && ara_req_i.is_last) begin
        wait_q <= 1'b1;
      end else if (owner_strobe) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      owner_q       <= ara_req_i.scalar[LaneIdxW-1:0];
      resp_result_q <= '0;
    end else if (owner_strobe) begin
      resp_result_q <= pe_resp_i[owner_q].value;
    end
  end

  assign ara_resp_o       = '{result: resp_result_q, error: 1'b0};
  assign ara_resp_valid_o = resp_valid_q;
  assign idle_o           = !busy_i && (&lanes_idle_i);

endmodule

/* filelist.f */
ara_pkg.sv
lane_vrf.sv
lane.sv
ara_sequencer.sv
ara_dispatcher.sv
ara.sv
ara_checker.sv
tb_ara.sv

/* lane.sv */
//////////////////////////////////////////////////////////////////////
// One vector lane, in-order, one element per cycle
// VLEN/(NrLanes*32) must be a power of two and at least 2
// Holds one running instruction plus a one-entry buffer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512,
  parameter int unsigned LaneId  = 0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  ara_pkg::pe_req_t  pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  output ara_pkg::pe_resp_t pe_resp_o,
  output logic              idle_o
);
  import ara_pkg::*;

  localparam int unsigned ElemPerLane = VLEN / (NrLanes * ElemWidth);
  localparam int unsigned ElemIdxW    = $clog2(ElemPerLane);
  localparam int unsigned LaneIdxW    = $clog2(NrLanes);
  localparam int unsigned Depth       = NrVRegs * ElemPerLane;
  localparam int unsigned AddrW       = $clog2(Depth);

  pe_req_t             run_q;
  pe_req_t             buf_q;
  logic                run_valid_q;
  logic                buf_valid_q;
  logic [ElemIdxW-1:0] cnt_q;
  logic                resp_valid_q;
  elem_t               resp_value_q;

  logic                accept;
  logic                run_done;
  logic                slot_free;
  logic                owner;
  logic [ElemIdxW-1:0] ext_idx;
  logic [AddrW-1:0]    raddr_a;
  logic [AddrW-1:0]    raddr_b;
  logic [AddrW-1:0]    waddr;
  logic                we;
  elem_t               rdata_a;
  elem_t               rdata_b;
  elem_t               wdata;

  assign pe_req_ready_o = !buf_valid_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  // Extract takes one cycle, the rest walk every local element
  assign run_done  = run_valid_q &&
                     (run_q.is_last || cnt_q == ElemIdxW'(ElemPerLane - 1));
  assign slot_free = !run_valid_q || run_done;

  // Element e sits in lane e mod NrLanes at index e div NrLanes
  assign owner   = run_q.scalar[LaneIdxW-1:0] == LaneIdxW'(LaneId);
  assign ext_idx = run_q.scalar[LaneIdxW +: ElemIdxW];

  assign raddr_a = {run_q.vs1, cnt_q};
  assign raddr_b = run_q.is_last ? {run_q.vs2, ext_idx} : {run_q.vs2, cnt_q};
  assign waddr   = {run_q.vd, cnt_q};
  assign we      = run_valid_q && !run_q.is_last;

  // Integer ALU
  always_comb begin
    case (run_q.op)
      OP_VADD:   wdata = rdata_a + rdata_b;
      OP_VXOR:   wdata = rdata_a ^ rdata_b;
      OP_VAND:   wdata = rdata_a & rdata_b;
      OP_VSPLAT: wdata = run_q.scalar;
      default:   wdata = '0;
    endcase
  end

  lane_vrf #(
    .Depth(Depth)
  ) i_vrf (
    .clk_i    (clk_i  ),
    .reset_i  (reset_i),
    .raddr_a_i(raddr_a),
    .raddr_b_i(raddr_b),
    .waddr_i  (waddr  ),
    .we_i     (we     ),
    .wdata_i  (wdata  ),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_valid_q  <= 1'b0;
      buf_valid_q  <= 1'b0;
      cnt_q        <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= run_valid_q && run_q.is_last && owner;
      if (slot_free) begin
        cnt_q       <= '0;
        run_valid_q <= buf_valid_q || accept;
        buf_valid_q <= 1'b0;
      end else begin
        cnt_q       <= cnt_q + 1'b1;
        buf_valid_q <= buf_valid_q || accept;
      end
    end
  end

  // Buffer is older than anything arriving now
  always_ff @(posedge clk_i) begin
    if (slot_free) begin
      if (buf_valid_q) begin
        run_q <= buf_q;
      end else if (accept) begin
        run_q <= pe_req_i;
      end
    end else if (accept) begin
      buf_q <= pe_req_i;
    end
    resp_value_q <= rdata_b;
  end

  assign pe_resp_o = '{valid: resp_valid_q, value: resp_value_q};
  assign idle_o    = !run_valid_q && !buf_valid_q;

endmodule

/* lane_vrf.sv */
//////////////////////////////////////////////////////////////////////
// Per-lane slice of the vector register file
// Two combinational read ports, one synchronous write port
// Depth must be a power of two, contents clear on reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_vrf #(
  parameter  int unsigned Depth = 32,
  localparam int unsigned AddrW = $clog2(Depth)
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [AddrW-1:0] raddr_a_i,
  input  logic [AddrW-1:0] raddr_b_i,
  input  logic [AddrW-1:0] waddr_i,
  input  logic             we_i,
  input  ara_pkg::elem_t   wdata_i,
  output ara_pkg::elem_t   rdata_a_o,
  output ara_pkg::elem_t   rdata_b_o
);
  import ara_pkg::*;

  // Register-major layout, local element index in the low bits
  elem_t mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value on a same-cycle write
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

/* tb_ara.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the vector accelerator, 4 lanes and VLEN of 512
// All inputs change on the falling clock edge
// One request at a time, random stalls on the response channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ara;
  import ara_pkg::*;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned VLEN          = 512;
  localparam int unsigned NrElems       = VLEN / ElemWidth;
  localparam int unsigned ElemPerLane   = VLEN / (NrLanes * ElemWidth);
  localparam int unsigned NumSplatReads = 12;
  localparam int unsigned NumMix        = 200;
  localparam int unsigned NumReqs       = 1 + NumSplatReads + NumMix + NrVRegs * NrElems;
  localparam int unsigned TimeoutCycles = NumReqs * (ElemPerLane * 3 + 20);

  logic        clk = 1'b0;
  logic        reset;
  acc_req_t    req;
  logic        req_valid;
  logic        req_ready;
  acc_resp_t   resp;
  logic        resp_valid;
  logic        resp_ready;
  logic        idle;
  logic        tests_done = 1'b0;
  logic        timed_out = 1'b0;
  logic        run_over;
  logic [31:0] lcg_state;
  int unsigned errors;

  always #10 clk = ~clk;

  assign run_over = tests_done || timed_out;

  ara #(
    .NrLanes(NrLanes),
    .VLEN   (VLEN   )
  ) dut_i (
    .clk_i           (clk       ),
    .reset_i         (reset     ),
    .acc_req_i       (req       ),
    .acc_req_valid_i (req_valid ),
    .acc_req_ready_o (req_ready ),
    .acc_resp_o      (resp      ),
    .acc_resp_valid_o(resp_valid),
    .acc_resp_ready_i(resp_ready),
    .idle_o          (idle      )
  );

  ara_checker #(
    .VLEN(VLEN)
  ) checker_i (
    .clk_i       (clk       ),
    .reset_i     (reset     ),
    .req_i       (req       ),
    .req_valid_i (req_valid ),
    .req_ready_i (req_ready ),
    .resp_i      (resp      ),
    .resp_valid_i(resp_valid),
    .resp_ready_i(resp_ready),
    .idle_i      (idle      ),
    .done_i      (run_over  ),
    .errors_o    (errors    )
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers and request builders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits of the LCG are the better ones
  function automatic int unsigned rand_below(int unsigned n);
    return (lcg_next() >> 8) % n;
  endfunction

  function automatic acc_req_t make_req(logic [2:0] op, vreg_t vd, vreg_t vs2, elem_t scalar);
    acc_req_t r;
    r.op     = op;
    r.vd     = vd;
    r.vs1    = '0;
    r.vs2    = vs2;
    r.scalar = scalar;
    return r;
  endfunction

  function automatic acc_req_t random_request();
    acc_req_t    r;
    int unsigned pick;
    pick     = rand_below(16);
    r.vd     = vreg_t'(rand_below(NrVRegs));
    r.vs1    = vreg_t'(rand_below(NrVRegs));
    r.vs2    = vreg_t'(rand_below(NrVRegs));
    r.scalar = lcg_next();
    if (pick < 3) begin
      r.op = 3'(OP_VADD);
    end else if (pick < 5) begin
      r.op = 3'(OP_VXOR);
    end else if (pick < 7) begin
      r.op = 3'(OP_VAND);
    end else if (pick < 9) begin
      r.op = 3'(OP_VSPLAT);
    end else if (pick < 14) begin
      // Index range twice the register to exercise the wrap
      r.op     = 3'(OP_VEXTRACT);
      r.scalar = elem_t'(rand_below(2 * NrElems));
    end else begin
      r.op = 3'(5 + rand_below(3));
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Core-side driving
  //////////////////////////////////////////////////////////////////////

  // One falling edge, core stalls the response about one cycle in four
  task automatic step();
    @(negedge clk);
    resp_ready = rand_below(4) != 0;
  endtask

  // Ready does not depend on valid, so it is read at the falling edge
  task automatic send_request(input acc_req_t r);
    step();
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      step();
    end
    step();
    req_valid = 1'b0;
  endtask

  initial begin
    vreg_t splat_reg;
    elem_t splat_val;

    lcg_state  = 32'ha2e9;
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Splat then read back, register zero stays untouched here
    splat_reg = vreg_t'(1 + rand_below(NrVRegs - 1));
    splat_val = lcg_next();
    send_request(make_req(3'(OP_VSPLAT), splat_reg, '0, splat_val));
    for (int i = 0; i < NumSplatReads; i++) begin
      send_request(make_req(3'(OP_VEXTRACT), '0, splat_reg, elem_t'(rand_below(2 * NrElems))));
    end

    for (int i = 0; i < NumMix; i++) begin
      send_request(random_request());
    end

    // Full sweep of the register file
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < NrElems; e++) begin
        send_request(make_req(3'(OP_VEXTRACT), '0, vreg_t'(r), elem_t'(e)));
      end
    end

    // Last response taken, then the lanes drain
    while (!req_ready) begin
      step();
    end
    while (!idle) begin
      step();
    end
    tests_done = 1'b1;
    repeat (2) step();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (!tests_done && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!tests_done) begin
      $display("ERROR: timeout after %0d cycles, the DUT stopped answering or never went idle",
               cycles);
      timed_out = 1'b1;
      repeat (2) @(negedge clk);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule
